// ==== mem_subsystem_settings.svh ====
`ifndef MEM_SUBSYSTEM_SETTINGS_SVH
`define MEM_SUBSYSTEM_SETTINGS_SVH

// byte address width of data accesses
`define MEM_ADDR_W 32

// data word width of four byte lanes
`define MEM_DATA_W 32

// power-of-two data ram depth in words
`define MEM_RAM_WORDS 256

// register file address width
`define MEM_REG_AW 5

`endif

// ==== lsu_pkg.sv ====
package lsu_pkg;

    // access size field shared by both views
    localparam logic [1:0] SZ_BYTE = 2'd0;
    localparam logic [1:0] SZ_HALF = 2'd1;
    localparam logic [1:0] SZ_WORD = 2'd2;

    // load side reading of the access code
    typedef struct packed {
        logic       is_unsigned; // zero-extend byte/half
        logic       is_store;
        logic [1:0] size;
    } mem_ld_view_t;

    // store side reading of the same code
    typedef struct packed {
        logic       rsvd;        // no meaning for stores
        logic       is_store;
        logic [1:0] size;
    } mem_st_view_t;

    // one 4-bit access code decoded two ways
    typedef union packed {
        mem_ld_view_t ld;
        mem_st_view_t st;
    } mem_op_u;

endpackage

// ==== mem_pipe_ctrl.sv ====
`timescale 1ns/1ns

module mem_pipe_ctrl (
    input  logic clk,
    input  logic resetn,
    input  logic in_valid,   // execute stage has an access
    input  logic wb_allowin, // write-back can take the slot
    output logic allowin,
    output logic accept,     // new access enters this edge
    output logic wb_valid
);

    logic slot_valid;

    // memory stage never stalls on its own, so ready_go is always true
    assign allowin  = ~slot_valid | wb_allowin;
    assign accept   = in_valid & allowin;
    assign wb_valid = slot_valid;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            slot_valid <= 1'b0;
        end else if (allowin) begin
            slot_valid <= in_valid; // refill or drain
        end
    end

endmodule

// ==== store_formatter.sv ====
`timescale 1ns/1ns
`include "mem_subsystem_settings.svh"

module store_formatter
    import lsu_pkg::*;
(
    input  mem_op_u                 in_op,
    input  logic [`MEM_ADDR_W-1:0]  in_addr,
    input  logic [`MEM_DATA_W-1:0]  in_store_data,
    output logic [3:0]              byte_we,
    output logic [`MEM_DATA_W-1:0]  ram_wdata
);

    logic [1:0] lane; // byte offset within the word

    assign lane = in_addr[1:0];

    always_comb begin
        byte_we   = 4'b0000;
        ram_wdata = in_store_data;
        if (in_op.st.is_store) begin
            case (in_op.st.size)
                SZ_BYTE: begin
                    byte_we   = 4'b0001 << lane; // lane 3 at offset 3
                    ram_wdata = {4{in_store_data[7:0]}};
                end
                SZ_HALF: begin
                    byte_we   = lane[1] ? 4'b1100 : 4'b0011;
                    ram_wdata = {2{in_store_data[15:0]}};
                end
                SZ_WORD: begin
                    byte_we   = 4'b1111;
                end
                default: begin
                    byte_we   = 4'b0000; // unused size code writes nothing
                end
            endcase
        end
    end

endmodule

// ==== load_aligner.sv ====
`timescale 1ns/1ns
`include "mem_subsystem_settings.svh"

module load_aligner
    import lsu_pkg::*;
(
    input  mem_op_u                 op,
    input  logic [1:0]              addr_low,
    input  logic [`MEM_DATA_W-1:0]  rdata,
    output logic [`MEM_DATA_W-1:0]  load_value
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    logic        byte_sign;
    logic        half_sign;

    always_comb begin
        case (addr_low)
            2'd0:    byte_sel = rdata[7:0];
            2'd1:    byte_sel = rdata[15:8];
            2'd2:    byte_sel = rdata[23:16];
            default: byte_sel = rdata[31:24];
        endcase
    end

    assign half_sel = addr_low[1] ? rdata[31:16] : rdata[15:0];

    // sign bit only when signed load
    assign byte_sign = ~op.ld.is_unsigned & byte_sel[7];
    assign half_sign = ~op.ld.is_unsigned & half_sel[15];

    always_comb begin
        case (op.ld.size)
            SZ_BYTE: load_value = {{(`MEM_DATA_W-8){byte_sign}}, byte_sel};
            SZ_HALF: load_value = {{(`MEM_DATA_W-16){half_sign}}, half_sel};
            default: load_value = rdata; // word
        endcase
    end

endmodule

// ==== data_ram.sv ====
`timescale 1ns/1ns
`include "mem_subsystem_settings.svh"

module data_ram #(
    parameter int WORDS = `MEM_RAM_WORDS,
    localparam int AW   = $clog2(WORDS)
) (
    input  logic                    clk,
    input  logic                    en,      // access issued this edge
    input  logic [3:0]              byte_we,
    input  logic [AW-1:0]           addr,    // word address
    input  logic [`MEM_DATA_W-1:0]  wdata,
    output logic [`MEM_DATA_W-1:0]  rdata
);

    logic [`MEM_DATA_W-1:0] mem [0:WORDS-1];

    // read register holds while en is low
    always_ff @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_we[i]) begin
                    mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
            rdata <= mem[addr]; // old word on a store
        end
    end

endmodule

// ==== mem_result_stage.sv ====
`timescale 1ns/1ns
`include "mem_subsystem_settings.svh"

module mem_result_stage
    import lsu_pkg::*;
(
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    accept,
    input  logic                    slot_valid,
    input  logic [`MEM_ADDR_W-1:0]  in_pc,
    input  mem_op_u                 in_op,
    input  logic [`MEM_ADDR_W-1:0]  in_addr,
    input  logic [`MEM_DATA_W-1:0]  in_alu_result,
    input  logic                    in_res_from_mem,
    input  logic                    in_rf_we,
    input  logic [`MEM_REG_AW-1:0]  in_rf_waddr,
    input  logic [`MEM_DATA_W-1:0]  load_value,  // aligned from held code
    output mem_op_u                 held_op,
    output logic [1:0]              held_addr_low,
    output logic                    wb_rf_we,
    output logic [`MEM_REG_AW-1:0]  wb_rf_waddr,
    output logic [`MEM_DATA_W-1:0]  wb_rf_wdata,
    output logic [`MEM_ADDR_W-1:0]  wb_pc,
    output logic                    fwd_rf_we,
    output logic [`MEM_REG_AW-1:0]  fwd_rf_waddr,
    output logic [`MEM_DATA_W-1:0]  fwd_rf_wdata
);

    logic                   res_from_mem;
    logic                   rf_we;
    logic [`MEM_DATA_W-1:0] alu_result;
    logic [`MEM_DATA_W-1:0] rf_wdata;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            res_from_mem <= 1'b0;
            rf_we        <= 1'b0;
        end else if (accept) begin
            res_from_mem <= in_res_from_mem;
            rf_we        <= in_rf_we;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (accept) begin
            wb_pc         <= in_pc;
            held_op       <= in_op;
            held_addr_low <= in_addr[1:0]; // only lane bits needed later
            alu_result    <= in_alu_result;
            wb_rf_waddr   <= in_rf_waddr;
        end
    end

    assign rf_wdata = res_from_mem ? load_value : alu_result;

    assign wb_rf_we    = rf_we & slot_valid;
    assign wb_rf_wdata = rf_wdata;

    // forward path mirrors the slot
    assign fwd_rf_we    = rf_we & slot_valid;
    assign fwd_rf_waddr = wb_rf_waddr;
    assign fwd_rf_wdata = rf_wdata;

endmodule

// ==== mem_subsystem.sv ====
`timescale 1ns/1ns
`include "mem_subsystem_settings.svh"

module mem_subsystem
    import lsu_pkg::*;
(
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    in_valid,
    input  logic [`MEM_ADDR_W-1:0]  in_pc,
    input  mem_op_u                 in_op,
    input  logic [`MEM_ADDR_W-1:0]  in_addr,
    input  logic [`MEM_DATA_W-1:0]  in_alu_result,
    input  logic                    in_res_from_mem,
    input  logic                    in_rf_we,
    input  logic [`MEM_REG_AW-1:0]  in_rf_waddr,
    input  logic [`MEM_DATA_W-1:0]  in_store_data,
    output logic                    allowin,
    input  logic                    wb_allowin,
    output logic                    wb_valid,
    output logic                    wb_rf_we,
    output logic [`MEM_REG_AW-1:0]  wb_rf_waddr,
    output logic [`MEM_DATA_W-1:0]  wb_rf_wdata,
    output logic [`MEM_ADDR_W-1:0]  wb_pc,
    output logic                    fwd_rf_we,
    output logic [`MEM_REG_AW-1:0]  fwd_rf_waddr,
    output logic [`MEM_DATA_W-1:0]  fwd_rf_wdata
);

    localparam int RAM_AW = $clog2(`MEM_RAM_WORDS);

    logic                   accept;
    logic [3:0]             byte_we;
    logic [`MEM_DATA_W-1:0] ram_wdata;
    logic [`MEM_DATA_W-1:0] ram_rdata;
    logic [`MEM_DATA_W-1:0] load_value;
    mem_op_u                held_op;
    logic [1:0]             held_addr_low;

    mem_pipe_ctrl u_ctrl (
        .clk        (clk),
        .resetn     (resetn),
        .in_valid   (in_valid),
        .wb_allowin (wb_allowin),
        .allowin    (allowin),
        .accept     (accept),
        .wb_valid   (wb_valid)
    );

    store_formatter u_store_fmt (
        .in_op         (in_op),
        .in_addr       (in_addr),
        .in_store_data (in_store_data),
        .byte_we       (byte_we),
        .ram_wdata     (ram_wdata)
    );

    data_ram #(
        .WORDS (`MEM_RAM_WORDS)
    ) u_ram (
        .clk     (clk),
        .en      (accept),
        .byte_we (byte_we),
        .addr    (in_addr[RAM_AW+1:2]), // byte to word address
        .wdata   (ram_wdata),
        .rdata   (ram_rdata)
    );

    load_aligner u_load_align (
        .op         (held_op),
        .addr_low   (held_addr_low),
        .rdata      (ram_rdata),
        .load_value (load_value)
    );

    mem_result_stage u_result (
        .clk             (clk),
        .resetn          (resetn),
        .accept          (accept),
        .slot_valid      (wb_valid),
        .in_pc           (in_pc),
        .in_op           (in_op),
        .in_addr         (in_addr),
        .in_alu_result   (in_alu_result),
        .in_res_from_mem (in_res_from_mem),
        .in_rf_we        (in_rf_we),
        .in_rf_waddr     (in_rf_waddr),
        .load_value      (load_value),
        .held_op         (held_op),
        .held_addr_low   (held_addr_low),
        .wb_rf_we        (wb_rf_we),
        .wb_rf_waddr     (wb_rf_waddr),
        .wb_rf_wdata     (wb_rf_wdata),
        .wb_pc           (wb_pc),
        .fwd_rf_we       (fwd_rf_we),
        .fwd_rf_waddr    (fwd_rf_waddr),
        .fwd_rf_wdata    (fwd_rf_wdata)
    );

endmodule

// ==== mem_subsystem_assertions.sv ====
`timescale 1ns/1ns

module mem_subsystem_assertions
    import lsu_pkg::*;
(
    input logic       clk,
    input logic       resetn,
    input logic       accept,
    input logic       wb_valid,
    input logic       wb_allowin,
    input mem_op_u    in_op,
    input logic [3:0] byte_we
);

    // slot must hold until write-back takes it
    a_hold_valid: assert property (@(posedge clk) disable iff (!resetn)
        wb_valid && !wb_allowin |=> wb_valid)
        else $error("wb_valid dropped under back-pressure");

    // a held slot takes no new access
    a_accept_gated: assert property (@(posedge clk) disable iff (!resetn)
        wb_valid && !wb_allowin |-> !accept)
        else $error("accept high while the full slot is back-pressured");

    // loads and alu results never write the ram
    a_no_strobe: assert property (@(posedge clk) disable iff (!resetn)
        !in_op.st.is_store |-> byte_we == 4'b0000)
        else $error("byte_we set for a non-store access");

endmodule

bind mem_subsystem mem_subsystem_assertions u_assert (
    .clk        (clk),
    .resetn     (resetn),
    .accept     (u_ctrl.accept),
    .wb_valid   (wb_valid),
    .wb_allowin (wb_allowin),
    .in_op      (in_op),
    .byte_we    (u_store_fmt.byte_we)
);

// ==== mem_subsystem_tb.sv ====
`timescale 1ns/1ns
`include "mem_subsystem_settings.svh"

module mem_subsystem_tb
    import lsu_pkg::*;
;

    localparam int MAX_TESTS = 64;
    localparam int LIMIT     = 200; // cycles per wait

    logic                    clk;
    logic                    resetn;
    logic                    in_valid;
    logic [`MEM_ADDR_W-1:0]  in_pc;
    mem_op_u                 in_op;
    logic [`MEM_ADDR_W-1:0]  in_addr;
    logic [`MEM_DATA_W-1:0]  in_alu_result;
    logic                    in_res_from_mem;
    logic                    in_rf_we;
    logic [`MEM_REG_AW-1:0]  in_rf_waddr;
    logic [`MEM_DATA_W-1:0]  in_store_data;
    logic                    allowin;
    logic                    wb_allowin;
    logic                    wb_valid;
    logic                    wb_rf_we;
    logic [`MEM_REG_AW-1:0]  wb_rf_waddr;
    logic [`MEM_DATA_W-1:0]  wb_rf_wdata;
    logic [`MEM_ADDR_W-1:0]  wb_pc;
    logic                    fwd_rf_we;
    logic [`MEM_REG_AW-1:0]  fwd_rf_waddr;
    logic [`MEM_DATA_W-1:0]  fwd_rf_wdata;

    // stimulus table with expected write-back
    string       t_name [MAX_TESTS];
    logic [3:0]  t_op   [MAX_TESTS];
    logic [31:0] t_addr [MAX_TESTS];
    logic [31:0] t_data [MAX_TESTS]; // store data and alu result
    logic        t_rfm  [MAX_TESTS];
    logic        t_we   [MAX_TESTS];
    logic [4:0]  t_wa   [MAX_TESTS];
    logic [31:0] t_exp  [MAX_TESTS];
    logic        t_bad  [MAX_TESTS];

    logic [7:0]  shadow [0:4*`MEM_RAM_WORDS-1]; // byte image of the ram
    int          n_tests;
    int          out_idx;
    int          errors;
    int          tries;
    logic        pending;   // wb_valid due after a transfer
    logic        transferred;
    logic        timed_out;
    integer      seed;

    mem_subsystem u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic add_entry(string nm, logic [3:0] op, logic [31:0] addr, logic [31:0] data,
                             logic rfm, logic we, logic [4:0] wa, logic [31:0] exp);
        t_name[n_tests] = nm;
        t_op[n_tests]   = op;
        t_addr[n_tests] = addr;
        t_data[n_tests] = data;
        t_rfm[n_tests]  = rfm;
        t_we[n_tests]   = we;
        t_wa[n_tests]   = wa;
        t_exp[n_tests]  = exp;
        t_bad[n_tests]  = 1'b0;
        n_tests++;
    endtask

    task automatic add_store(string nm, logic [1:0] size, logic [31:0] addr, logic [31:0] data);
        int a;
        a = int'(addr[9:0]);
        case (size)
            SZ_BYTE: shadow[a] = data[7:0];
            SZ_HALF: begin
                a = a & ~1;
                shadow[a]     = data[7:0];
                shadow[a + 1] = data[15:8];
            end
            default: begin
                a = a & ~3;
                for (int i = 0; i < 4; i++) shadow[a + i] = data[i*8 +: 8];
            end
        endcase
        // stores write nothing back but still carry the alu field
        add_entry(nm, {2'b01, size}, addr, data, 1'b0, 1'b0, 5'd0, data);
    endtask

    task automatic add_load(string nm, logic [1:0] size, logic uns, logic [31:0] addr,
                            logic [4:0] wa);
        int          a;
        logic [7:0]  b;
        logic [15:0] h;
        logic [31:0] exp;
        a = int'(addr[9:0]);
        b = shadow[a];
        h = {shadow[(a & ~1) + 1], shadow[a & ~1]};
        case (size)
            SZ_BYTE: exp = uns ? {24'd0, b} : {{24{b[7]}}, b};
            SZ_HALF: exp = uns ? {16'd0, h} : {{16{h[15]}}, h};
            default: begin
                a   = a & ~3;
                exp = {shadow[a + 3], shadow[a + 2], shadow[a + 1], shadow[a]};
            end
        endcase
        add_entry(nm, {uns, 1'b0, size}, addr, 32'h0, 1'b1, 1'b1, wa, exp);
    endtask

    task automatic check_value(int idx, string what, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            $display("ERROR %s %s: expected %h, actual %h", t_name[idx], what, exp, act);
            errors++;
            t_bad[idx] = 1'b1;
        end
    endtask

    // check outputs at a falling edge, then pick back-pressure and retire
    task automatic step_cycle();
        @(negedge clk);
        if (pending && !wb_valid) begin
            $display("wb_valid did not rise one cycle after a transfer");
            errors++;
        end
        pending = 1'b0;
        if (!wb_valid && fwd_rf_we) begin
            $display("fwd_rf_we is high with an empty slot");
            errors++;
        end
        if (wb_valid && out_idx >= n_tests) begin
            $display("wb_valid is high with no access outstanding");
            errors++;
        end else if (wb_valid) begin
            check_value(out_idx, "wdata", t_exp[out_idx], wb_rf_wdata);
            check_value(out_idx, "we", {31'd0, t_we[out_idx]}, {31'd0, wb_rf_we});
            check_value(out_idx, "pc", 32'h1000 + 4 * out_idx, wb_pc);
            check_value(out_idx, "fwd we", {31'd0, t_we[out_idx]}, {31'd0, fwd_rf_we});
            check_value(out_idx, "fwd wdata", t_exp[out_idx], fwd_rf_wdata);
            if (t_we[out_idx]) begin
                check_value(out_idx, "waddr", {27'd0, t_wa[out_idx]}, {27'd0, wb_rf_waddr});
                check_value(out_idx, "fwd waddr", {27'd0, t_wa[out_idx]},
                            {27'd0, fwd_rf_waddr});
            end
        end
        wb_allowin = ($random(seed) & 3) != 0;
        if (wb_valid && wb_allowin && out_idx < n_tests) begin
            $display("test %s %s", t_name[out_idx], t_bad[out_idx] ? "failed" : "ok");
            out_idx++;
        end
    endtask

    task automatic drive_entry(int i);
        in_valid        = 1'b1;
        in_pc           = 32'h1000 + 4 * i;
        in_op           = t_op[i];
        in_addr         = t_addr[i];
        in_alu_result   = t_data[i];
        in_store_data   = t_data[i];
        in_res_from_mem = t_rfm[i];
        in_rf_we        = t_we[i];
        in_rf_waddr     = t_wa[i];
    endtask

    initial begin
        seed = 32'he15c_5cff;
        n_tests = 0;
        out_idx = 0;
        errors = 0;
        pending = 1'b0;
        timed_out = 1'b0;
        resetn = 1'b0;
        in_valid = 1'b0;
        in_pc = '0;
        in_op = '0;
        in_addr = '0;
        in_alu_result = '0;
        in_res_from_mem = 1'b0;
        in_rf_we = 1'b0;
        in_rf_waddr = '0;
        in_store_data = '0;
        wb_allowin = 1'b1;
        for (int i = 0; i < 4 * `MEM_RAM_WORDS; i++) shadow[i] = 8'h00;

        add_store("st_w0", SZ_WORD, 32'h40, 32'h1122_3344);
        add_store("st_w1", SZ_WORD, 32'h44, 32'h8899_aabb);
        add_store("st_w2", SZ_WORD, 32'h48, 32'hf07f_8001);
        add_store("st_b3", SZ_BYTE, 32'h43, 32'h0000_00a5); // top lane
        add_store("st_b1", SZ_BYTE, 32'h41, 32'hffff_ff7e);
        add_store("st_h2", SZ_HALF, 32'h46, 32'h0000_c35a);
        add_store("st_h0", SZ_HALF, 32'h44, 32'h1234_0e0d);
        add_load("ld_w0", SZ_WORD, 1'b0, 32'h40, 5'd1);
        add_load("ld_w1", SZ_WORD, 1'b0, 32'h44, 5'd2);
        for (int k = 0; k < 4; k++) begin
            add_load($sformatf("lb_%0d", k), SZ_BYTE, 1'b0, 32'h48 + k, 5'(3 + k));
            add_load($sformatf("lbu_%0d", k), SZ_BYTE, 1'b1, 32'h48 + k, 5'(7 + k));
        end
        add_load("lh_0", SZ_HALF, 1'b0, 32'h48, 5'd11);
        add_load("lh_2", SZ_HALF, 1'b0, 32'h4a, 5'd12);
        add_load("lhu_0", SZ_HALF, 1'b1, 32'h48, 5'd13);
        add_load("lhu_2", SZ_HALF, 1'b1, 32'h4a, 5'd14);
        add_entry("alu_we", 4'b0010, 32'h0, 32'hdead_beef, 1'b0, 1'b1, 5'd20, 32'hdead_beef);
        add_entry("alu_no_we", 4'b0010, 32'h0, 32'h0bad_cafe, 1'b0, 1'b0, 5'd21, 32'h0bad_cafe);

        repeat (3) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
        #1;
        if (wb_valid || fwd_rf_we || !allowin) begin
            $display("outputs after reset are wrong: wb_valid %b fwd_rf_we %b allowin %b",
                     wb_valid, fwd_rf_we, allowin);
            errors++;
        end

        for (int i = 0; i < n_tests && !timed_out; i++) begin
            tries = 0;
            transferred = 1'b0;
            while (!transferred && !timed_out) begin
                step_cycle();
                drive_entry(i);
                #1;
                if (allowin) begin
                    transferred = 1'b1;
                    pending = 1'b1;
                end else begin
                    tries++;
                    if (tries > LIMIT) begin
                        $display("timeout waiting for allowin on test %s", t_name[i]);
                        errors++;
                        timed_out = 1'b1;
                    end
                end
            end
        end

        tries = 0;
        while (out_idx < n_tests && !timed_out) begin
            step_cycle();
            in_valid = 1'b0;
            tries++;
            if (tries > LIMIT) begin
                $display("timeout waiting for wb_valid to drain the pipeline");
                errors++;
                timed_out = 1'b1;
            end
        end

        $display("tests %0d, errors %0d", n_tests, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== mem_subsystem.f ====
+incdir+.
lsu_pkg.sv
mem_pipe_ctrl.sv
store_formatter.sv
load_aligner.sv
data_ram.sv
mem_result_stage.sv
mem_subsystem.sv
mem_subsystem_assertions.sv
mem_subsystem_tb.sv

// ==== Makefile ====
TOP = mem_subsystem_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

obj_dir/V$(TOP): *.sv *.svh mem_subsystem.f
	verilator --binary --timing --assert --top-module $(TOP) -f mem_subsystem.f

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Done: no errors"

clean:
	rm -rf obj_dir
